//--- files.f
pip_types_pkg.sv
inst_predecoder.sv
issue_queue.sv
iq_top.sv
tb_iq_checker.sv
tb_iq.sv

//--- inst_predecoder.sv
`timescale 1ns/10ps

module inst_predecoder #(
  parameter int INS_COUNT = 4
) (
  input  logic                                        clock,
  input  logic                                        reset_n,
  input  logic                                        flush_i,

  input  logic                                        fetch_valid_i,
  input  logic [$clog2(INS_COUNT+1)-1:0]              fetch_count_i,
  input  pip_types_pkg::fetch_word_t [INS_COUNT-1:0]  fetch_words_i,

  output logic                                        ins_valid_o,
  output logic [$clog2(INS_COUNT+1)-1:0]              ins_count_o,
  output pip_types_pkg::dec_inst_t [INS_COUNT-1:0]    ins_entries_o
);

  import pip_types_pkg::*;

  // slot that the first word of the next bundle receives.
  logic [ROB_SLOT_W-1:0]     slot_q;
  dec_inst_t [INS_COUNT-1:0] dec_d;

  // classify every word position. Positions beyond the count are decoded too
  // but never reach the queue, since ins_count_o limits the write.
  always_comb begin
    for (int i = 0; i < INS_COUNT; i++) begin
      dec_d[i].pc          = fetch_words_i[i].pc;
      dec_d[i].fields      = fetch_words_i[i].word;
      dec_d[i].is_reg_form = (dec_d[i].fields.reg_form.opcode == OP_REG_FORM);
      // slots wrap at the reorder buffer size by truncation.
      dec_d[i].rob_slot    = slot_q + ROB_SLOT_W'(i);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ins_valid_o <= 1'b0;
      ins_count_o <= '0;
      slot_q      <= '0;
    end else if (flush_i) begin
      // a bundle held here belongs to the squashed path.
      ins_valid_o <= 1'b0;
      ins_count_o <= '0;
      slot_q      <= '0;
    end else begin
      ins_valid_o <= fetch_valid_i;
      ins_count_o <= fetch_valid_i ? fetch_count_i : '0;
      if (fetch_valid_i) begin
        slot_q <= slot_q + ROB_SLOT_W'(fetch_count_i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid_i) begin
      ins_entries_o <= dec_d;
    end
  end

  // the producer sends between one and INS_COUNT words per bundle.
  a_fetch_count_range : assert property (
    @(posedge clock) disable iff (!reset_n)
    fetch_valid_i |-> (fetch_count_i != '0 && int'(fetch_count_i) <= INS_COUNT)
  ) else $error("predecoder: fetch_count_i %0d out of range", fetch_count_i);

endmodule

//--- iq_top.sv
`timescale 1ns/10ps

module iq_top #(
  parameter int DEPTH     = 16,
  parameter int INS_COUNT = 4,
  parameter int EXT_COUNT = 4
) (
  input  logic                                        clock,
  input  logic                                        reset_n,
  input  logic                                        flush_i,

  input  logic                                        fetch_valid_i,
  input  logic [$clog2(INS_COUNT+1)-1:0]              fetch_count_i,
  input  pip_types_pkg::fetch_word_t [INS_COUNT-1:0]  fetch_words_i,

  input  logic [$clog2(EXT_COUNT+1)-1:0]              take_i,
  output pip_types_pkg::dec_inst_t [EXT_COUNT-1:0]    window_o,
  output logic [EXT_COUNT-1:0]                        window_valid_o,

  output logic [$clog2(EXT_COUNT+1)-1:0]              credit_return_o,
  output logic [$clog2(DEPTH):0]                      occupancy_o
);

  import pip_types_pkg::*;

  logic                               ins_valid;
  logic [$clog2(INS_COUNT+1)-1:0]     ins_count;
  dec_inst_t [INS_COUNT-1:0]          ins_entries;

  inst_predecoder #(
    .INS_COUNT (INS_COUNT)
  ) u_predecoder (
    .clock         (clock),
    .reset_n       (reset_n),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_count_i (fetch_count_i),
    .fetch_words_i (fetch_words_i),
    .ins_valid_o   (ins_valid),
    .ins_count_o   (ins_count),
    .ins_entries_o (ins_entries)
  );

  issue_queue #(
    .DEPTH     (DEPTH),
    .INS_COUNT (INS_COUNT),
    .EXT_COUNT (EXT_COUNT)
  ) u_queue (
    .clock           (clock),
    .reset_n         (reset_n),
    .flush_i         (flush_i),
    .ins_valid_i     (ins_valid),
    .ins_count_i     (ins_count),
    .ins_entries_i   (ins_entries),
    .take_i          (take_i),
    .window_o        (window_o),
    .window_valid_o  (window_valid_o),
    .credit_return_o (credit_return_o),
    .occupancy_o     (occupancy_o)
  );

endmodule

//--- issue_queue.sv
`timescale 1ns/10ps

module issue_queue #(
  parameter int DEPTH     = 16,
  parameter int INS_COUNT = 4,
  parameter int EXT_COUNT = 4
) (
  input  logic                                      clock,
  input  logic                                      reset_n,
  input  logic                                      flush_i,

  input  logic                                      ins_valid_i,
  input  logic [$clog2(INS_COUNT+1)-1:0]            ins_count_i,
  input  pip_types_pkg::dec_inst_t [INS_COUNT-1:0]  ins_entries_i,

  input  logic [$clog2(EXT_COUNT+1)-1:0]            take_i,
  output pip_types_pkg::dec_inst_t [EXT_COUNT-1:0]  window_o,
  output logic [EXT_COUNT-1:0]                      window_valid_o,

  output logic [$clog2(EXT_COUNT+1)-1:0]            credit_return_o,
  output logic [$clog2(DEPTH):0]                    occupancy_o
);

  import pip_types_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int OCC_W = PTR_W + 1;
  localparam int INS_W = $clog2(INS_COUNT + 1);

  dec_inst_t mem_q [DEPTH];

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [OCC_W-1:0] occ_q;

  // number of words written this cycle.
  logic [INS_W-1:0] ins_n;

  assign ins_n = ins_valid_i ? ins_count_i : '0;

  // the window is read straight from storage, oldest entry at position 0.
  // pointer sums wrap on their own because DEPTH is a power of two.
  always_comb begin
    for (int i = 0; i < EXT_COUNT; i++) begin
      window_o[i]       = mem_q[head_q + PTR_W'(i)];
      window_valid_o[i] = (occ_q > OCC_W'(i));
    end
  end

  assign occupancy_o = occ_q;

  always_ff @(posedge clock) begin
    if (!flush_i) begin
      for (int i = 0; i < INS_COUNT; i++) begin
        if (i < int'(ins_n)) begin
          mem_q[tail_q + PTR_W'(i)] <= ins_entries_i[i];
        end
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head_q          <= '0;
      tail_q          <= '0;
      occ_q           <= '0;
      credit_return_o <= '0;
    end else if (flush_i) begin
      // a take in the flush cycle is dropped, so no credit comes back for it.
      head_q          <= '0;
      tail_q          <= '0;
      occ_q           <= '0;
      credit_return_o <= '0;
    end else begin
      head_q          <= head_q + PTR_W'(take_i);
      tail_q          <= tail_q + PTR_W'(ins_n);
      occ_q           <= occ_q + OCC_W'(ins_n) - OCC_W'(take_i);
      credit_return_o <= take_i;
    end
  end

  // with correct credit keeping on the producer side the queue never overflows.
  a_no_overflow : assert property (
    @(posedge clock) disable iff (!reset_n)
    !flush_i |-> (int'(occ_q) + int'(ins_n) - int'(take_i)) <= DEPTH
  ) else $error("issue_queue: insert of %0d words overflows occupancy %0d", ins_n, occ_q);

  // the consumer takes only entries that it can see in the window.
  a_take_in_window : assert property (
    @(posedge clock) disable iff (!reset_n)
    int'(take_i) <= $countones(window_valid_o)
  ) else $error("issue_queue: take %0d beyond valid window", take_i);

endmodule

//--- pip_types_pkg.sv
package pip_types_pkg;

  // program counter and instruction word width.
  localparam int XLEN = 32;

  // reorder buffer has 64 entries.
  localparam int ROB_SLOT_W = 6;

  localparam int OPCODE_W = 7;
  localparam int REG_W    = 5;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;
  localparam int IMM12_W  = 12;

  // any other opcode is read as immediate form.
  localparam logic [OPCODE_W-1:0] OP_REG_FORM = 7'b0110011;

  // one word of a fetch bundle together with its program counter.
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] word;
  } fetch_word_t;

  // fields are declared from the top bit down, so the opcode sits in bits 6 to 0.
  typedef struct packed {
    logic [FUNCT7_W-1:0] funct7;
    logic [REG_W-1:0]    rs2;
    logic [REG_W-1:0]    rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [REG_W-1:0]    rd;
    logic [OPCODE_W-1:0] opcode;
  } reg_form_t;

  typedef struct packed {
    logic [IMM12_W-1:0]  imm12;
    logic [REG_W-1:0]    rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [REG_W-1:0]    rd;
    logic [OPCODE_W-1:0] opcode;
  } imm_form_t;

  // the same 32-bit word, read either as register form or as immediate form.
  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } inst_fields_u;

  // an entry of the issue queue as written by the predecoder.
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    inst_fields_u          fields;
    logic                  is_reg_form;
    logic [ROB_SLOT_W-1:0] rob_slot;
  } dec_inst_t;

endpackage

//--- run.sh
#!/bin/sh
# Builds the issue queue testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_iq \
  -f files.f

if ./obj_dir/Vtb_iq | tee /dev/stderr | grep -q -x "TEST OK"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb_iq.sv
`timescale 1ns/10ps

module tb_iq;

  import pip_types_pkg::*;

  localparam int DEPTH     = 16;
  localparam int INS_COUNT = 4;
  localparam int EXT_COUNT = 4;
  localparam int FCNT_W    = $clog2(INS_COUNT + 1);
  localparam int TAKE_W    = $clog2(EXT_COUNT + 1);

  logic                           clock = 1'b0;
  logic                           reset_n;
  logic                           flush_i;
  logic                           fetch_valid_i;
  logic [FCNT_W-1:0]              fetch_count_i;
  fetch_word_t [INS_COUNT-1:0]    fetch_words_i;
  logic [TAKE_W-1:0]              take_i;
  dec_inst_t [EXT_COUNT-1:0]      window_o;
  logic [EXT_COUNT-1:0]           window_valid_o;
  logic [TAKE_W-1:0]              credit_return_o;
  logic [$clog2(DEPTH):0]         occupancy_o;

  // producer credit bookkeeping.
  int              credits;
  int              cr_seen;
  logic            flush_sent;
  logic [XLEN-1:0] next_pc;

  int error_count;
  int check_count;
  bit timed_out;

  always #50 clock = ~clock;

  iq_top #(
    .DEPTH     (DEPTH),
    .INS_COUNT (INS_COUNT),
    .EXT_COUNT (EXT_COUNT)
  ) UUT (
    .clock           (clock),
    .reset_n         (reset_n),
    .flush_i         (flush_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_count_i   (fetch_count_i),
    .fetch_words_i   (fetch_words_i),
    .take_i          (take_i),
    .window_o        (window_o),
    .window_valid_o  (window_valid_o),
    .credit_return_o (credit_return_o),
    .occupancy_o     (occupancy_o)
  );

  tb_iq_checker #(
    .DEPTH     (DEPTH),
    .INS_COUNT (INS_COUNT),
    .EXT_COUNT (EXT_COUNT)
  ) u_checker (
    .clock              (clock),
    .reset_n            (reset_n),
    .flush_i            (flush_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_count_i      (fetch_count_i),
    .fetch_words_i      (fetch_words_i),
    .take_i             (take_i),
    .window_i           (window_o),
    .window_valid_i     (window_valid_o),
    .credit_return_i    (credit_return_o),
    .occupancy_i        (occupancy_o),
    .producer_credits_i (credits),
    .error_count_o      (error_count),
    .check_count_o      (check_count)
  );

  function automatic logic [XLEN-1:0] random_word();
    logic [XLEN-1:0] w;
    w = $urandom;
    // about half of the words are forced to register form.
    if ($urandom % 2 == 0) begin
      w[6:0] = OP_REG_FORM;
    end
    return w;
  endfunction

  task automatic drive_cycle(input int fetch_pct, input int take_pct, input int flush_permille);
    int fc;
    int n_valid;
    @(posedge clock);
    #5;
    // the edge just passed returned credits, or restored all of them on a flush.
    if (flush_sent) begin
      credits = DEPTH;
    end else begin
      credits = credits + cr_seen;
    end
    cr_seen       = int'(credit_return_o);
    flush_sent    = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_count_i = '0;
    take_i        = '0;
    for (int i = 0; i < INS_COUNT; i++) begin
      fetch_words_i[i].pc   = $urandom;
      fetch_words_i[i].word = random_word();
    end
    if (int'($urandom % 1000) < flush_permille) begin
      flush_i    = 1'b1;
      flush_sent = 1'b1;
    end
    fc = 1 + int'($urandom % INS_COUNT);
    if (!flush_i && credits >= fc && int'($urandom % 100) < fetch_pct) begin
      fetch_valid_i = 1'b1;
      fetch_count_i = FCNT_W'(fc);
      credits       = credits - fc;
      for (int i = 0; i < fc; i++) begin
        fetch_words_i[i].pc = next_pc;
        next_pc             = next_pc + 32'd4;
      end
    end
    if (int'($urandom % 100) < take_pct) begin
      n_valid = $countones(window_valid_o);
      take_i  = TAKE_W'($urandom % (n_valid + 1));
    end
  endtask

  task automatic drain_queue(input string name);
    bit empty;
    empty = 1'b0;
    for (int cyc = 0; cyc < 200 && !empty; cyc++) begin
      drive_cycle(0, 100, 0);
      empty = (occupancy_o == '0) && (credits == DEPTH) && (cr_seen == 0) && !flush_sent;
    end
    if (!empty) begin
      $display("timeout: queue did not drain within 200 cycles in test %s", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input string name, input int cycles, input int fetch_pct,
                          input int take_pct, input int flush_permille);
    int errors_before;
    // once a drain has timed out the queue state is unknown, so later tests are skipped.
    if (timed_out) begin
      return;
    end
    errors_before = error_count;
    for (int cyc = 0; cyc < cycles; cyc++) begin
      drive_cycle(fetch_pct, take_pct, flush_permille);
    end
    drain_queue(name);
    @(negedge clock);
    #1;
    $display("test %s: %0d cycles, %0d errors", name, cycles, error_count - errors_before);
  endtask

  initial begin
    void'($urandom(98501));
    reset_n       = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_count_i = '0;
    fetch_words_i = '0;
    take_i        = '0;
    credits       = DEPTH;
    cr_seen       = 0;
    flush_sent    = 1'b0;
    timed_out     = 1'b0;
    next_pc       = 32'h0000_1000;
    repeat (3) @(posedge clock);
    #5;
    reset_n = 1'b1;

    run_test("insert order and latency", 200, 60, 50, 0);
    run_test("full queue", 200, 100, 20, 0);
    run_test("slot wrap", 300, 90, 90, 0);
    run_test("flush", 400, 80, 60, 30);

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb_iq_checker.sv
`timescale 1ns/10ps

module tb_iq_checker #(
  parameter int DEPTH     = 16,
  parameter int INS_COUNT = 4,
  parameter int EXT_COUNT = 4
) (
  input  logic                                        clock,
  input  logic                                        reset_n,
  input  logic                                        flush_i,
  input  logic                                        fetch_valid_i,
  input  logic [$clog2(INS_COUNT+1)-1:0]              fetch_count_i,
  input  pip_types_pkg::fetch_word_t [INS_COUNT-1:0]  fetch_words_i,
  input  logic [$clog2(EXT_COUNT+1)-1:0]              take_i,
  input  pip_types_pkg::dec_inst_t [EXT_COUNT-1:0]    window_i,
  input  logic [EXT_COUNT-1:0]                        window_valid_i,
  input  logic [$clog2(EXT_COUNT+1)-1:0]              credit_return_i,
  input  logic [$clog2(DEPTH):0]                      occupancy_i,
  input  int                                          producer_credits_i,
  output int                                          error_count_o,
  output int                                          check_count_o
);

  import pip_types_pkg::*;

  dec_inst_t             queue_model[$];
  dec_inst_t             stage_model[$];
  logic [ROB_SLOT_W-1:0] slot_model;
  int                    expected_credit;
  logic [XLEN-1:0]       highest_pc;
  logic [XLEN-1:0]       flush_pc;
  logic                  flushed;

  // inputs seen at a falling edge are the ones the next rising edge samples.
  logic                        pending;
  logic                        p_flush;
  logic                        p_fetch_valid;
  int                          p_fetch_count;
  fetch_word_t [INS_COUNT-1:0] p_words;
  int                          p_take;

  int errors = 0;
  int checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic dec_inst_t predecode(input fetch_word_t fw,
                                          input logic [ROB_SLOT_W-1:0] slot);
    dec_inst_t d;
    d.pc          = fw.pc;
    d.fields      = fw.word;
    d.is_reg_form = (fw.word[6:0] == OP_REG_FORM);
    d.rob_slot    = slot;
    return d;
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t %s", $time, msg);
    errors = errors + 1;
  endtask

  task automatic apply_edge();
    if (p_flush) begin
      queue_model.delete();
      stage_model.delete();
      slot_model      = '0;
      expected_credit = 0;
      flush_pc        = highest_pc;
      flushed         = 1'b1;
    end else begin
      if (p_take > queue_model.size()) begin
        $display("protocol error at %0t: take of %0d with only %0d entries queued",
                 $time, p_take, queue_model.size());
        errors = errors + 1;
      end
      for (int i = 0; i < p_take && queue_model.size() > 0; i++) begin
        void'(queue_model.pop_front());
      end
      expected_credit = p_take;
      // the bundle held in the predecode register moves into the queue.
      foreach (stage_model[i]) begin
        queue_model.push_back(stage_model[i]);
      end
      stage_model.delete();
      if (p_fetch_valid) begin
        for (int i = 0; i < p_fetch_count; i++) begin
          stage_model.push_back(predecode(p_words[i], slot_model));
          slot_model = slot_model + ROB_SLOT_W'(1);
          if (p_words[i].pc > highest_pc) begin
            highest_pc = p_words[i].pc;
          end
        end
      end
    end
  endtask

  task automatic compare_outputs();
    dec_inst_t       got;
    dec_inst_t       exp;
    logic [XLEN-1:0] w;
    logic            exp_valid;
    int              in_flight;
    checks = checks + 1;
    for (int i = 0; i < EXT_COUNT; i++) begin
      exp_valid = (i < queue_model.size());
      got       = window_i[i];
      if (window_valid_i[i] !== exp_valid) begin
        report_error($sformatf("window_valid[%0d] is %b, expected %b",
                               i, window_valid_i[i], exp_valid));
      end else if (exp_valid) begin
        exp = queue_model[i];
        w   = exp.fields;
        if (got.pc !== exp.pc || got.fields !== exp.fields) begin
          report_error($sformatf("window[%0d] pc %h word %h, expected pc %h word %h",
                                 i, got.pc, got.fields, exp.pc, w));
        end
        if (got.is_reg_form !== exp.is_reg_form) begin
          report_error($sformatf("window[%0d] is_reg_form %b, expected %b",
                                 i, got.is_reg_form, exp.is_reg_form));
        end
        if (got.rob_slot !== exp.rob_slot) begin
          report_error($sformatf("window[%0d] rob_slot %0d, expected %0d",
                                 i, got.rob_slot, exp.rob_slot));
        end
        if (got.fields.reg_form.rd !== w[11:7] || got.fields.reg_form.funct3 !== w[14:12] ||
            got.fields.reg_form.rs1 !== w[19:15] || got.fields.reg_form.rs2 !== w[24:20] ||
            got.fields.reg_form.funct7 !== w[31:25] ||
            got.fields.reg_form.opcode !== w[6:0]) begin
          report_error($sformatf("window[%0d] register form fields do not match %h", i, w));
        end
        if (got.fields.imm_form.imm12 !== w[31:20] || got.fields.imm_form.rs1 !== w[19:15] ||
            got.fields.imm_form.funct3 !== w[14:12] || got.fields.imm_form.rd !== w[11:7] ||
            got.fields.imm_form.opcode !== w[6:0]) begin
          report_error($sformatf("window[%0d] immediate form fields do not match %h", i, w));
        end
        if (flushed && got.pc <= flush_pc) begin
          report_error($sformatf("window[%0d] shows pc %h from before the last flush",
                                 i, got.pc));
        end
      end
    end
    if (int'(occupancy_i) != queue_model.size()) begin
      report_error($sformatf("occupancy %0d, expected %0d", occupancy_i, queue_model.size()));
    end
    if (int'(credit_return_i) != expected_credit) begin
      report_error($sformatf("credit_return %0d, expected %0d", credit_return_i, expected_credit));
    end
    // credits held, queued, in predecode, presented or on their way back add up to DEPTH.
    in_flight = stage_model.size() + expected_credit + (fetch_valid_i ? int'(fetch_count_i) : 0);
    if (producer_credits_i + queue_model.size() + in_flight != DEPTH) begin
      report_error($sformatf("credit sum %0d, expected %0d",
                             producer_credits_i + queue_model.size() + in_flight, DEPTH));
    end
  endtask

  always @(negedge clock) begin
    if (!reset_n) begin
      queue_model.delete();
      stage_model.delete();
      slot_model      = '0;
      expected_credit = 0;
      highest_pc      = '0;
      flush_pc        = '0;
      flushed         = 1'b0;
      pending         = 1'b0;
    end else begin
      if (pending) begin
        apply_edge();
      end
      compare_outputs();
      p_flush       = flush_i;
      p_fetch_valid = fetch_valid_i;
      p_fetch_count = int'(fetch_count_i);
      p_words       = fetch_words_i;
      p_take        = int'(take_i);
      pending       = 1'b1;
    end
  end

endmodule
